// File: include/mips_isa.svh
`ifndef MIPS_ISA_SVH
`define MIPS_ISA_SVH

// primary opcode field, inst[31:26]
localparam logic [5:0] OP_SPECIAL = 6'h00;
localparam logic [5:0] OP_ADDIU   = 6'h09;
localparam logic [5:0] OP_ORI     = 6'h0d;
localparam logic [5:0] OP_LUI     = 6'h0f;

// funct field of SPECIAL, inst[5:0]
localparam logic [5:0] FN_SLL   = 6'h00;
localparam logic [5:0] FN_SRL   = 6'h02;
localparam logic [5:0] FN_MFHI  = 6'h10;
localparam logic [5:0] FN_MFLO  = 6'h12;
localparam logic [5:0] FN_MULT  = 6'h18;
localparam logic [5:0] FN_MULTU = 6'h19;
localparam logic [5:0] FN_ADDU  = 6'h21;
localparam logic [5:0] FN_SUBU  = 6'h23;
localparam logic [5:0] FN_AND   = 6'h24;
localparam logic [5:0] FN_OR    = 6'h25;
localparam logic [5:0] FN_XOR   = 6'h26;
localparam logic [5:0] FN_SLT   = 6'h2a;

`endif

// File: mips_top.f
+incdir+include
rtl/mips_pkg.sv
rtl/mips_fetch.sv
rtl/mips_regfile.sv
rtl/mips_decode.sv
rtl/mips_alu.sv
rtl/mips_hilo.sv
rtl/mips_writeback.sv
rtl/mips_top.sv
verification/mips_top_checker.sv
verification/tb_mips_top.sv

// File: rtl/mips_alu.sv
`timescale 1ns/1ps

module mips_alu import mips_pkg::*; (
    input  issue_t issue_i,
    output gpr_t   result_o
);

    gpr_t a;
    gpr_t b;

    assign a = issue_i.src_a;
    assign b = issue_i.src_b;

    always_comb begin
        case (issue_i.alu_op)
            ALU_ADD:    result_o = a + b;
            ALU_SUB:    result_o = a - b;
            ALU_AND:    result_o = a & b;
            ALU_OR:     result_o = a | b;
            ALU_XOR:    result_o = a ^ b;
            // signed compare for slt
            ALU_SLT:    result_o = {31'd0, $signed(a) < $signed(b)};
            // shifts act on rt, carried in src_b
            ALU_SLL:    result_o = b << issue_i.shamt;
            ALU_SRL:    result_o = b >> issue_i.shamt;
            ALU_PASS_B: result_o = b;
            default:    result_o = '0;
        endcase
    end

endmodule

// File: rtl/mips_decode.sv
`timescale 1ns/1ps

module mips_decode import mips_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  fetch_t    fetch_i,
    output gpr_addr_t rs_addr_o,
    output gpr_addr_t rt_addr_o,
    input  gpr_t      rs_data_i,
    input  gpr_t      rt_data_i,
    input  wb_t       ex_fwd_i,
    input  wb_t       wb_fwd_i,
    output issue_t    issue_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    gpr_addr_t   rs;
    gpr_addr_t   rt;
    gpr_addr_t   rd;
    gpr_t        rs_val;
    gpr_t        rt_val;
    issue_t      issue_d;
    issue_t      issue_q;

    // youngest producer wins
    function automatic gpr_t forward(gpr_addr_t addr, gpr_t rf_data, wb_t ex_w, wb_t wb_w);
        if (ex_w.valid && ex_w.addr == addr) begin
            return ex_w.data;
        end else if (wb_w.valid && wb_w.addr == addr) begin
            return wb_w.data;
        end
        return rf_data;
    endfunction

    assign opcode = fetch_i.inst[31:26];
    assign rs     = fetch_i.inst[25:21];
    assign rt     = fetch_i.inst[20:16];
    assign rd     = fetch_i.inst[15:11];
    assign funct  = fetch_i.inst[5:0];
    assign imm    = fetch_i.inst[15:0];

    assign rs_addr_o = rs;
    assign rt_addr_o = rt;

    assign rs_val = forward(rs, rs_data_i, ex_fwd_i, wb_fwd_i);
    assign rt_val = forward(rt, rt_data_i, ex_fwd_i, wb_fwd_i);

    always_comb begin
        issue_d.valid   = fetch_i.valid;
        issue_d.alu_op  = ALU_PASS_B;
        issue_d.hilo_op = HILO_NONE;
        issue_d.src_a   = rs_val;
        issue_d.src_b   = rt_val;
        issue_d.shamt   = fetch_i.inst[10:6];
        issue_d.dest    = rd;
        issue_d.wr_en   = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                issue_d.wr_en = 1'b1;
                case (funct)
                    FN_ADDU:  issue_d.alu_op = ALU_ADD;
                    FN_SUBU:  issue_d.alu_op = ALU_SUB;
                    FN_AND:   issue_d.alu_op = ALU_AND;
                    FN_OR:    issue_d.alu_op = ALU_OR;
                    FN_XOR:   issue_d.alu_op = ALU_XOR;
                    FN_SLT:   issue_d.alu_op = ALU_SLT;
                    FN_SLL:   issue_d.alu_op = ALU_SLL;
                    FN_SRL:   issue_d.alu_op = ALU_SRL;
                    FN_MFHI:  issue_d.hilo_op = HILO_MFHI;
                    FN_MFLO:  issue_d.hilo_op = HILO_MFLO;
                    FN_MULT: begin
                        issue_d.hilo_op = HILO_MULT;
                        issue_d.wr_en   = 1'b0;
                    end
                    FN_MULTU: begin
                        issue_d.hilo_op = HILO_MULTU;
                        issue_d.wr_en   = 1'b0;
                    end
                    default:  issue_d.wr_en = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                issue_d.alu_op = ALU_ADD;
                issue_d.src_b  = {{16{imm[15]}}, imm};
                issue_d.dest   = rt;
                issue_d.wr_en  = 1'b1;
            end
            OP_ORI: begin
                issue_d.alu_op = ALU_OR;
                issue_d.src_b  = {16'h0000, imm};
                issue_d.dest   = rt;
                issue_d.wr_en  = 1'b1;
            end
            OP_LUI: begin
                issue_d.src_b = {imm, 16'h0000};
                issue_d.dest  = rt;
                issue_d.wr_en = 1'b1;
            end
            default: begin
            end
        endcase

        // writes to $0 are dropped here so nothing forwards them
        if (issue_d.dest == '0) begin
            issue_d.wr_en = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            issue_q <= '0;
        end else begin
            issue_q <= issue_d;
        end
    end

    assign issue_o = issue_q;

endmodule

// File: rtl/mips_fetch.sv
`timescale 1ns/1ps

module mips_fetch import mips_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  logic   clk_i,
    input  logic   arst_n_i,
    output addr_t  inst_sram_addr_o,
    input  inst_t  inst_sram_rdata_i,
    output fetch_t fetch_o
);

    addr_t pc_q;
    addr_t fetch_pc_q;
    logic  fetch_valid_q;

    // no stalls, so the pc free-runs
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q          <= RESET_PC;
            fetch_pc_q    <= RESET_PC;
            fetch_valid_q <= 1'b0;
        end else begin
            pc_q          <= pc_q + 32'd4;
            fetch_pc_q    <= pc_q;
            fetch_valid_q <= 1'b1;
        end
    end

    assign inst_sram_addr_o = pc_q;

    // sram data lands one cycle behind its address
    assign fetch_o = '{valid: fetch_valid_q, pc: fetch_pc_q, inst: inst_sram_rdata_i};

endmodule

// File: rtl/mips_hilo.sv
`timescale 1ns/1ps

module mips_hilo import mips_pkg::*; (
    input  logic   clk_i,
    input  logic   arst_n_i,
    input  issue_t issue_i,
    output gpr_t   result_o
);

    gpr_t               hi_q;
    gpr_t               lo_q;
    logic signed [63:0] prod_s;
    logic        [63:0] prod_u;

    assign prod_s = $signed(issue_i.src_a) * $signed(issue_i.src_b);
    assign prod_u = issue_i.src_a * issue_i.src_b;

    // written at the end of the multiply's execute cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (issue_i.valid && issue_i.hilo_op == HILO_MULT) begin
            hi_q <= prod_s[63:32];
            lo_q <= prod_s[31:0];
        end else if (issue_i.valid && issue_i.hilo_op == HILO_MULTU) begin
            hi_q <= prod_u[63:32];
            lo_q <= prod_u[31:0];
        end
    end

    always_comb begin
        case (issue_i.hilo_op)
            HILO_MFHI: result_o = hi_q;
            HILO_MFLO: result_o = lo_q;
            default:   result_o = '0;
        endcase
    end

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

    `include "mips_isa.svh"

    typedef logic [31:0] gpr_t;
    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  gpr_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        HILO_NONE,
        HILO_MULT,
        HILO_MULTU,
        HILO_MFHI,
        HILO_MFLO
    } hilo_op_e;

    // word returned by the instruction SRAM, tagged with its address
    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } fetch_t;

    // operands already resolved, shamt only read by shifts
    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        hilo_op_e  hilo_op;
        gpr_t      src_a;
        gpr_t      src_b;
        logic [4:0] shamt;
        gpr_addr_t dest;
        logic      wr_en;
    } issue_t;

    typedef struct packed {
        logic      valid;
        gpr_addr_t addr;
        gpr_t      data;
    } wb_t;

endpackage

// File: rtl/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile import mips_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  gpr_addr_t rs_addr_i,
    input  gpr_addr_t rt_addr_i,
    input  wb_t       wb_i,
    output gpr_t      rs_data_o,
    output gpr_t      rt_data_o
);

    gpr_t regs [32];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.addr != '0) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // $0 is never written, so it reads zero
    assign rs_data_o = regs[rs_addr_i];
    assign rt_data_o = regs[rt_addr_i];

endmodule

// File: rtl/mips_top.sv
`timescale 1ns/1ps

module mips_top import mips_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk_i,
    input  logic  arst_n_i,
    output addr_t inst_sram_addr_o,
    input  inst_t inst_sram_rdata_i,
    output wb_t   retire_o
);

    fetch_t    fetch;
    issue_t    issue;
    gpr_addr_t rs_addr;
    gpr_addr_t rt_addr;
    gpr_t      rs_data;
    gpr_t      rt_data;
    gpr_t      alu_result;
    gpr_t      hilo_result;
    wb_t       ex_result;
    wb_t       wb;

    mips_fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .inst_sram_addr_o  (inst_sram_addr_o),
        .inst_sram_rdata_i (inst_sram_rdata_i),
        .fetch_o           (fetch)
    );

    mips_regfile u_regfile (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .wb_i      (wb),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

    mips_decode u_decode (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .fetch_i   (fetch),
        .rs_addr_o (rs_addr),
        .rt_addr_o (rt_addr),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .ex_fwd_i  (ex_result),
        .wb_fwd_i  (wb),
        .issue_o   (issue)
    );

    mips_alu u_alu (
        .issue_i  (issue),
        .result_o (alu_result)
    );

    mips_hilo u_hilo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .issue_i  (issue),
        .result_o (hilo_result)
    );

    mips_writeback u_writeback (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .issue_i       (issue),
        .alu_result_i  (alu_result),
        .hilo_result_i (hilo_result),
        .ex_result_o   (ex_result),
        .wb_o          (wb)
    );

    assign retire_o = wb;

endmodule

// File: rtl/mips_writeback.sv
`timescale 1ns/1ps

module mips_writeback import mips_pkg::*; (
    input  logic   clk_i,
    input  logic   arst_n_i,
    input  issue_t issue_i,
    input  gpr_t   alu_result_i,
    input  gpr_t   hilo_result_i,
    output wb_t    ex_result_o,
    output wb_t    wb_o
);

    logic hilo_read;
    wb_t  wb_q;

    assign hilo_read = (issue_i.hilo_op == HILO_MFHI) || (issue_i.hilo_op == HILO_MFLO);

    // also the execute-stage forwarding source
    assign ex_result_o.valid = issue_i.valid && issue_i.wr_en;
    assign ex_result_o.addr  = issue_i.dest;
    assign ex_result_o.data  = hilo_read ? hilo_result_i : alu_result_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= ex_result_o;
        end
    end

    assign wb_o = wb_q;

endmodule

// File: verification/mips_top_checker.sv
`timescale 1ns/1ps

module mips_top_checker import mips_pkg::*; (
    input logic  clk_i,
    input logic  arst_n_i,
    input addr_t inst_sram_addr_o,
    input wb_t   retire_o
);

    retire_quiet_in_reset: assert property (
        @(posedge clk_i) !arst_n_i |-> !retire_o.valid
    ) else $error("retire_o.valid high while reset is asserted");

    // $0 writes never leave decode
    retire_not_r0: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) retire_o.valid |-> retire_o.addr != '0
    ) else $error("write to register 0 retired");

    fetch_aligned: assert property (
        @(posedge clk_i) inst_sram_addr_o[1:0] == 2'b00
    ) else $error("instruction address %h not word aligned", inst_sram_addr_o);

    fetch_sequential: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $past(arst_n_i) |-> inst_sram_addr_o == $past(inst_sram_addr_o) + 32'd4
    ) else $error("instruction address did not advance by 4");

endmodule

bind mips_top mips_top_checker u_checker (.*);

// File: verification/tb_mips_top.sv
`timescale 1ns/1ps

module tb_mips_top import mips_pkg::*; ();

    localparam addr_t RESET_PC  = 32'h0000_0100;
    localparam int    NUM_TESTS = 6;
    localparam int    LATENCY   = 3;

    // one expected register write, tagged with its test and program slot
    typedef struct packed {
        logic [7:0] test;
        logic [7:0] slot;
        wb_t        wr;
    } exp_t;

    logic  clk_i;
    logic  arst_n_i;
    inst_t inst_sram_rdata_i;
    addr_t inst_sram_addr_o;
    wb_t   retire_o;

    inst_t prog [$];
    exp_t  exp_q [$];
    string test_name [NUM_TESTS];
    int    test_errs [NUM_TESTS];
    int    cycle_count;
    int    max_cycles;
    int    exp_idx;
    int    errors;
    int    tests_failed;

    mips_top #(
        .RESET_PC(RESET_PC)
    ) u_dut (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .inst_sram_addr_o  (inst_sram_addr_o),
        .inst_sram_rdata_i (inst_sram_rdata_i),
        .retire_o          (retire_o)
    );

    always #2 clk_i = ~clk_i;

    function automatic inst_t r_type(int rs, int rt, int rd, int sa, logic [5:0] fn);
        return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic inst_t i_type(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // past the end of the program the memory reads zero
    function automatic inst_t fetch_word(addr_t a);
        int unsigned idx;
        idx = (a - RESET_PC) >> 2;
        if (idx < prog.size()) begin
            return prog[idx];
        end
        return '0;
    endfunction

    task automatic add_row(inst_t word, int test, logic writes, int rd, gpr_t data);
        exp_t e;
        e.test = 8'(test);
        e.slot = 8'(prog.size());
        e.wr   = '{valid: 1'b1, addr: 5'(rd), data: data};
        prog.push_back(word);
        if (writes) begin
            exp_q.push_back(e);
        end
    endtask

    task automatic load_tables();
        test_name = '{"reset and fetch order", "immediates", "forwarding", "shifts",
                      "multiply", "silent writes"};
        add_row(i_type(OP_LUI, 0, 1, 16'h1234), 1, 1'b1, 1, 32'h1234_0000);
        add_row(i_type(OP_ORI, 1, 1, 16'h5678), 1, 1'b1, 1, 32'h1234_5678);
        add_row(i_type(OP_ADDIU, 0, 2, 16'hffff), 1, 1'b1, 2, 32'hffff_ffff);
        add_row(i_type(OP_ADDIU, 1, 3, 16'h8000), 1, 1'b1, 3, 32'h1233_d678);
        add_row(i_type(OP_ORI, 0, 4, 16'h00ff), 1, 1'b1, 4, 32'h0000_00ff);
        // operands one and two slots back
        add_row(r_type(1, 4, 5, 0, FN_ADDU), 2, 1'b1, 5, 32'h1234_5777);
        add_row(r_type(5, 2, 6, 0, FN_SUBU), 2, 1'b1, 6, 32'h1234_5778);
        add_row(r_type(6, 5, 7, 0, FN_AND), 2, 1'b1, 7, 32'h1234_5770);
        add_row(r_type(7, 4, 8, 0, FN_OR), 2, 1'b1, 8, 32'h1234_57ff);
        add_row(r_type(8, 7, 9, 0, FN_XOR), 2, 1'b1, 9, 32'h0000_008f);
        add_row(r_type(2, 9, 10, 0, FN_SLT), 2, 1'b1, 10, 32'h0000_0001);
        add_row(r_type(9, 2, 11, 0, FN_SLT), 2, 1'b1, 11, 32'h0000_0000);
        add_row(r_type(0, 1, 12, 4, FN_SLL), 3, 1'b1, 12, 32'h2345_6780);
        add_row(r_type(0, 12, 13, 8, FN_SRL), 3, 1'b1, 13, 32'h0023_4567);
        add_row(r_type(0, 2, 14, 31, FN_SRL), 3, 1'b1, 14, 32'h0000_0001);
        add_row(r_type(0, 13, 15, 12, FN_SLL), 3, 1'b1, 15, 32'h3456_7000);
        // signed -1 times 0x12345678 then unsigned 0xffffffff squared
        add_row(r_type(2, 1, 0, 0, FN_MULT), 4, 1'b0, 0, '0);
        add_row(r_type(0, 0, 16, 0, FN_MFHI), 4, 1'b1, 16, 32'hffff_ffff);
        add_row(r_type(0, 0, 17, 0, FN_MFLO), 4, 1'b1, 17, 32'hedcb_a988);
        add_row(r_type(2, 2, 0, 0, FN_MULTU), 4, 1'b0, 0, '0);
        add_row(r_type(0, 0, 18, 0, FN_MFHI), 4, 1'b1, 18, 32'hffff_fffe);
        add_row(r_type(0, 0, 19, 0, FN_MFLO), 4, 1'b1, 19, 32'h0000_0001);
        add_row(i_type(OP_ADDIU, 1, 0, 16'h0005), 5, 1'b0, 0, '0);
        add_row(32'hfc21_b001, 5, 1'b0, 0, '0);
        add_row(r_type(1, 1, 0, 0, FN_ADDU), 5, 1'b0, 0, '0);
        add_row(r_type(1, 1, 22, 0, FN_MULT), 5, 1'b0, 0, '0);
        add_row(r_type(0, 4, 20, 0, FN_ADDU), 5, 1'b1, 20, 32'h0000_00ff);
        add_row(r_type(0, 0, 21, 0, FN_OR), 5, 1'b1, 21, 32'h0000_0000);
    endtask

    task automatic check_addr(addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: fetch address %h, expected %h", $time, got, exp);
            errors++;
            test_errs[0]++;
        end
    endtask

    task automatic check_wb(wb_t got, wb_t exp, int test);
        if (got !== exp) begin
            $display("FAILED at time %0t: retired $%0d = %h, expected $%0d = %h",
                     $time, got.addr, got.data, exp.addr, exp.data);
            errors++;
            test_errs[test]++;
        end
    endtask

    task automatic report_test(int t);
        if (test_errs[t] == 0) begin
            $display("test %0d (%s): passed", t, test_name[t]);
        end else begin
            $display("test %0d (%s): failed with %0d errors", t, test_name[t], test_errs[t]);
            tests_failed++;
        end
    endtask

    always @(posedge clk_i) begin
        inst_sram_rdata_i <= fetch_word(inst_sram_addr_o);
    end

    always @(posedge clk_i) begin
        if (arst_n_i) begin
            cycle_count <= cycle_count + 1;
        end
    end

    // outputs are sampled half a cycle after they change
    always @(negedge clk_i) begin
        exp_t e;
        if (!arst_n_i) begin
            if (retire_o.valid) begin
                $display("a register write retired while reset was asserted");
                errors++;
                test_errs[0]++;
            end
        end else begin
            check_addr(inst_sram_addr_o, RESET_PC + 32'(4 * cycle_count));
            if (retire_o.valid && exp_idx >= exp_q.size()) begin
                $display("unexpected write to $%0d after the last expected write", retire_o.addr);
                errors++;
            end else if (retire_o.valid) begin
                e = exp_q[exp_idx];
                if (cycle_count != int'(e.slot) + LATENCY) begin
                    $display("FAILED at time %0t: write to $%0d retired in cycle %0d, expected %0d",
                             $time, retire_o.addr, cycle_count, int'(e.slot) + LATENCY);
                    errors++;
                    test_errs[e.test]++;
                end
                check_wb(retire_o, e.wr, e.test);
                exp_idx++;
                if (exp_idx == exp_q.size() || exp_q[exp_idx].test != e.test) begin
                    report_test(e.test);
                end
            end
        end
    end

    initial begin
        clk_i             = 1'b0;
        arst_n_i          = 1'b0;
        inst_sram_rdata_i = '0;
        cycle_count       = 0;
        exp_idx           = 0;
        errors            = 0;
        tests_failed      = 0;
        test_errs         = '{default: 0};
        load_tables();
        max_cycles = prog.size() + LATENCY + 20;

        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;

        while (exp_idx < exp_q.size() && cycle_count < max_cycles) begin
            @(posedge clk_i);
        end

        if (exp_idx < exp_q.size()) begin
            $display("timeout after %0d cycles, only %0d of %0d expected writes retired",
                     cycle_count, exp_idx, exp_q.size());
            errors++;
        end else begin
            // drain so a stray write after the last one is caught
            repeat (LATENCY + 2) @(posedge clk_i);
        end

        // fetch addresses are checked for the whole run
        report_test(0);

        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
